// ==== hdl/executePkg.sv ====
`default_nettype none

package executePkg;

    localparam int DataWidth = 32;              // MIPS word

    // --------------------
    // ALUControl codes
    // --------------------
    localparam logic [5:0] opAdd   = 6'd0;      // ADD, ADDI
    localparam logic [5:0] opAddu  = 6'd1;      // ADDU, ADDIU
    localparam logic [5:0] opSub   = 6'd2;
    localparam logic [5:0] opMul   = 6'd3;      // Low word only
    localparam logic [5:0] opMult  = 6'd4;      // HI/LO signed product
    localparam logic [5:0] opMultu = 6'd5;      // HI/LO unsigned product
    localparam logic [5:0] opMadd  = 6'd6;      // HI/LO += product
    localparam logic [5:0] opMsub  = 6'd7;      // HI/LO -= product
    localparam logic [5:0] opBgez  = 6'd8;
    localparam logic [5:0] opBeq   = 6'd9;
    localparam logic [5:0] opBne   = 6'd10;
    localparam logic [5:0] opBgtz  = 6'd11;
    localparam logic [5:0] opBlez  = 6'd12;
    localparam logic [5:0] opBltz  = 6'd13;
    localparam logic [5:0] opJump  = 6'd14;     // Register jump
    localparam logic [5:0] opSrav  = 6'd15;
    localparam logic [5:0] opRotrv = 6'd16;
    localparam logic [5:0] opLui   = 6'd17;
    localparam logic [5:0] opAnd   = 6'd18;
    localparam logic [5:0] opOr    = 6'd19;
    localparam logic [5:0] opNor   = 6'd20;
    localparam logic [5:0] opXor   = 6'd21;
    localparam logic [5:0] opSeh   = 6'd22;     // Sign extend halfword
    localparam logic [5:0] opSll   = 6'd23;
    localparam logic [5:0] opSrl   = 6'd24;
    localparam logic [5:0] opMovn  = 6'd25;
    localparam logic [5:0] opMovz  = 6'd26;
    localparam logic [5:0] opRotr  = 6'd27;
    localparam logic [5:0] opSra   = 6'd28;
    localparam logic [5:0] opSeb   = 6'd29;     // Sign extend byte
    localparam logic [5:0] opSlt   = 6'd30;
    localparam logic [5:0] opSltu  = 6'd31;
    localparam logic [5:0] opMthi  = 6'd32;
    localparam logic [5:0] opMtlo  = 6'd33;
    localparam logic [5:0] opMfhi  = 6'd34;
    localparam logic [5:0] opMflo  = 6'd35;
    localparam logic [5:0] opSllv  = 6'd36;
    localparam logic [5:0] opSrlv  = 6'd37;
    localparam logic [5:0] opAbs   = 6'd43;
    localparam logic [5:0] opLa    = 6'd44;     // Low 24 bits of B
    localparam logic [5:0] opSubu  = 6'd45;

    // --------------------
    // Stage bundles
    // --------------------
    typedef struct packed {
        logic                 Valid;            // One-cycle strobe
        logic                 RegWrite;
        logic [5:0]           ALUControl;
        logic [DataWidth-1:0] A;                // rs value
        logic [DataWidth-1:0] B;                // rt value or immediate
        logic [4:0]           Shamt;
        logic [4:0]           DestReg;
        logic [DataWidth-1:0] PcPlus4;
        logic [15:0]          BranchOffset;     // Signed word offset
    } issueBundleT;

    typedef struct packed {
        logic                 Valid;
        logic                 RegWrite;         // Cleared on failed move
        logic [4:0]           DestReg;
        logic [DataWidth-1:0] Result;
        logic                 Zero;             // Result is all zeros
        logic                 BranchTaken;
        logic [DataWidth-1:0] BranchTarget;
    } executeResultT;

    typedef struct packed {
        logic [DataWidth-1:0] Hi;
        logic [DataWidth-1:0] Lo;
    } hiLoPairT;

endpackage

`default_nettype wire

// ==== hdl/issueRegister.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueRegister import executePkg::*; (
    input  logic        Clk,
    input  logic        reset,
    input  issueBundleT Issue,                  // From decode
    output issueBundleT Latched                 // Operation in execute cycle
);

    issueBundleT bundleQ;                       // Operands and code
    logic        validQ;                        // Control bits, reset to a bubble
    logic        regWriteQ;

    // --------------------
    // Payload capture
    // --------------------
    always_ff @(posedge Clk) begin
        bundleQ <= Issue;                       // Whole word every cycle
    end

    // --------------------
    // Control capture
    // --------------------
    always_ff @(posedge Clk) begin
        if (reset) begin
            validQ    <= 1'b0;                  // Bubble after reset
            regWriteQ <= 1'b0;
        end else begin
            validQ    <= Issue.Valid;
            regWriteQ <= Issue.RegWrite;
        end
    end

    // Reassemble with the reset-cleared control bits
    always_comb begin
        Latched          = bundleQ;
        Latched.Valid    = validQ;
        Latched.RegWrite = regWriteQ;
    end

endmodule

`default_nettype wire

// ==== hdl/aluCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluCore import executePkg::*; (
    input  issueBundleT          Latched,       // Operation in execute
    output logic [DataWidth-1:0] AluResult,     // Single-result value
    output logic                 MoveFail       // MOVN or MOVZ condition not met
);

    logic [DataWidth-1:0] a;                    // Operand shorthands
    logic [DataWidth-1:0] b;
    logic [4:0]           varAmount;            // Low five bits of A
    logic [DataWidth-1:0] rotFixed;             // ROTR by Shamt
    logic [DataWidth-1:0] rotVar;               // ROTRV by A
    logic                 bIsZero;

    assign a         = Latched.A;
    assign b         = Latched.B;
    assign varAmount = Latched.A[4:0];
    assign bIsZero   = (b == '0);

    // Rotate as a shift of B doubled, low word kept
    assign rotFixed = DataWidth'({b, b} >> Latched.Shamt);
    assign rotVar   = DataWidth'({b, b} >> varAmount);

    always_comb begin
        AluResult = '0;                         // Unlisted codes give zero
        MoveFail  = 1'b0;
        case (Latched.ALUControl)
            // --------------------
            // Arithmetic
            // --------------------
            opAdd, opAddu: begin
                AluResult = a + b;              // Same bits signed or not
            end
            opSub, opSubu: begin
                AluResult = a - b;              // No overflow trap
            end
            opMul: begin
                AluResult = a * b;              // Low word of product
            end
            opAbs: begin
                AluResult = a[DataWidth-1] ? -a : a;
            end
            opLa: begin
                AluResult = {8'h00, b[23:0]};
            end
            opLui: begin
                AluResult = {b[15:0], 16'h0000};
            end

            // --------------------
            // Logic and extend
            // --------------------
            opAnd: AluResult = a & b;
            opOr:  AluResult = a | b;
            opNor: AluResult = ~(a | b);
            opXor: AluResult = a ^ b;
            opSeh: begin
                AluResult = {{16{b[15]}}, b[15:0]};
            end
            opSeb: begin
                AluResult = {{24{b[7]}}, b[7:0]};
            end

            // --------------------
            // Shifts and rotates
            // --------------------
            opSll:   AluResult = b << Latched.Shamt;
            opSllv:  AluResult = b << varAmount;
            opSrl:   AluResult = b >> Latched.Shamt;
            opSrlv:  AluResult = b >> varAmount;
            opSra:   AluResult = $signed(b) >>> Latched.Shamt;  // Sign fill
            opSrav:  AluResult = $signed(b) >>> varAmount;
            opRotr:  AluResult = rotFixed;
            opRotrv: AluResult = rotVar;

            // --------------------
            // Conditional moves
            // --------------------
            opMovn: begin
                if (!bIsZero) begin
                    AluResult = a;              // Move when B nonzero
                end else begin
                    MoveFail = 1'b1;            // Suppress write
                end
            end
            opMovz: begin
                if (bIsZero) begin
                    AluResult = a;              // Move when B zero
                end else begin
                    MoveFail = 1'b1;
                end
            end

            // Set on less than, one-bit result
            opSlt: begin
                AluResult = {{(DataWidth-1){1'b0}}, $signed(a) < $signed(b)};
            end
            opSltu: begin
                AluResult = {{(DataWidth-1){1'b0}}, a < b};
            end

            default: begin
                AluResult = '0;                 // HI/LO and branch codes too
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/hiLoUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hiLoUnit import executePkg::*; (
    input  logic                 Clk,
    input  logic                 reset,
    input  issueBundleT          Latched,       // Operation in execute
    output logic [DataWidth-1:0] HiLoRead       // HI for MFHI, else LO
);

    hiLoPairT                      hiLo;        // Architectural HI and LO
    hiLoPairT                      hiLoNext;
    logic signed [2*DataWidth-1:0] signedProd;  // MULT, MADD, MSUB
    logic        [2*DataWidth-1:0] unsignedProd;
    logic                          writesHiLo;  // Code touches the pair

    // Full 64-bit products, single cycle
    assign signedProd   = $signed(Latched.A) * $signed(Latched.B);
    assign unsignedProd = Latched.A * Latched.B;

    // --------------------
    // Next HI/LO value
    // --------------------
    always_comb begin
        hiLoNext   = hiLo;                      // Hold by default
        writesHiLo = 1'b1;
        case (Latched.ALUControl)
            opMult: begin
                hiLoNext = hiLoPairT'(signedProd);
            end
            opMultu: begin
                hiLoNext = hiLoPairT'(unsignedProd);
            end
            opMadd: begin
                hiLoNext = hiLoPairT'(hiLo + signedProd);   // Accumulate
            end
            opMsub: begin
                hiLoNext = hiLoPairT'(hiLo - signedProd);
            end
            opMthi: begin
                hiLoNext.Hi = Latched.A;        // LO untouched
            end
            opMtlo: begin
                hiLoNext.Lo = Latched.A;        // HI untouched
            end
            default: begin
                writesHiLo = 1'b0;
            end
        endcase
    end

    // --------------------
    // HI/LO registers
    // --------------------
    // Written at the end of the execute cycle, so a move-from
    // issued right behind sees the new pair
    always_ff @(posedge Clk) begin
        if (reset) begin
            hiLo <= '0;
        end else if (Latched.Valid && writesHiLo) begin
            hiLo <= hiLoNext;                   // Bubbles never update
        end
    end

    // Read from current registers, no bypass
    always_comb begin
        if (Latched.ALUControl == opMfhi) begin
            HiLoRead = hiLo.Hi;
        end else begin
            HiLoRead = hiLo.Lo;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/branchResolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchResolve import executePkg::*; (
    input  issueBundleT          Latched,       // Operation in execute
    output logic                 Taken,
    output logic [DataWidth-1:0] Target
);

    logic [DataWidth-1:0] offsetExt;            // Byte offset, sign extended
    logic                 aNeg;
    logic                 aZero;
    logic                 condition;            // Raw branch outcome

    assign offsetExt = {{(DataWidth-18){Latched.BranchOffset[15]}},
                        Latched.BranchOffset, 2'b00};
    assign aNeg      = Latched.A[DataWidth-1];
    assign aZero     = (Latched.A == '0);

    always_comb begin
        case (Latched.ALUControl)
            opBeq:   condition = (Latched.A == Latched.B);
            opBne:   condition = (Latched.A != Latched.B);
            opBgez:  condition = !aNeg;
            opBgtz:  condition = !aNeg && !aZero;
            opBlez:  condition = aNeg || aZero;
            opBltz:  condition = aNeg;
            opJump:  condition = 1'b1;          // Always taken
            default: condition = 1'b0;          // Not a branch
        endcase
    end

    assign Taken = Latched.Valid && condition;  // Bubbles never branch

    // Register jump uses A, branches are PC relative
    assign Target = (Latched.ALUControl == opJump) ? Latched.A
                                                   : Latched.PcPlus4 + offsetExt;

endmodule

`default_nettype wire

// ==== hdl/resultRegister.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultRegister import executePkg::*; (
    input  logic                 Clk,
    input  logic                 reset,
    input  issueBundleT          Latched,       // Operation in execute
    input  logic [DataWidth-1:0] AluResult,
    input  logic                 MoveFail,
    input  logic [DataWidth-1:0] HiLoRead,
    input  logic                 Taken,
    input  logic [DataWidth-1:0] Target,
    output executeResultT        Execute        // To next stage
);

    logic [DataWidth-1:0] selResult;            // Final result word
    executeResultT        nextResult;
    executeResultT        payloadQ;             // Result, target, dest
    logic                 validQ;
    logic                 regWriteQ;
    logic                 takenQ;

    // --------------------
    // Result select
    // --------------------
    always_comb begin
        case (Latched.ALUControl)
            opMfhi, opMflo: selResult = HiLoRead;
            opMult, opMultu, opMadd, opMsub, opMthi, opMtlo: begin
                selResult = '0;                 // HI/LO writers show zero
            end
            default: selResult = AluResult;
        endcase
    end

    always_comb begin
        nextResult.Valid        = Latched.Valid;
        nextResult.RegWrite     = Latched.Valid && Latched.RegWrite && !MoveFail;
        nextResult.DestReg      = Latched.DestReg;
        nextResult.Result       = selResult;
        nextResult.Zero         = (selResult == '0);
        nextResult.BranchTaken  = Taken;
        nextResult.BranchTarget = Target;
    end

    always_ff @(posedge Clk) begin
        payloadQ <= nextResult;                 // Data fields
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            validQ    <= 1'b0;
            regWriteQ <= 1'b0;
            takenQ    <= 1'b0;
        end else begin
            validQ    <= nextResult.Valid;
            regWriteQ <= nextResult.RegWrite;
            takenQ    <= nextResult.BranchTaken;
        end
    end

    always_comb begin
        Execute             = payloadQ;
        Execute.Valid       = validQ;           // Control from reset flops
        Execute.RegWrite    = regWriteQ;
        Execute.BranchTaken = takenQ;
    end

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage import executePkg::*; (
    input  logic          Clk,
    input  logic          reset,
    input  issueBundleT   Issue,                // From decode
    output executeResultT Execute               // Two cycles after Issue
);

    issueBundleT          latched;              // Operation in execute cycle
    logic [DataWidth-1:0] aluResult;
    logic                 moveFail;
    logic [DataWidth-1:0] hiLoRead;
    logic                 taken;
    logic [DataWidth-1:0] target;

    // --------------------
    // Input side
    // --------------------
    issueRegister uIssue (
        .Clk     (Clk),
        .reset   (reset),
        .Issue   (Issue),
        .Latched (latched)
    );

    // --------------------
    // Processing part
    // --------------------
    aluCore uAlu (
        .Latched   (latched),
        .AluResult (aluResult),
        .MoveFail  (moveFail)
    );

    hiLoUnit uHiLo (
        .Clk      (Clk),
        .reset    (reset),
        .Latched  (latched),
        .HiLoRead (hiLoRead)
    );

    branchResolve uBranch (
        .Latched (latched),
        .Taken   (taken),
        .Target  (target)
    );

    // --------------------
    // Output side
    // --------------------
    resultRegister uResult (
        .Clk       (Clk),
        .reset     (reset),
        .Latched   (latched),
        .AluResult (aluResult),
        .MoveFail  (moveFail),
        .HiLoRead  (hiLoRead),
        .Taken     (taken),
        .Target    (target),
        .Execute   (Execute)
    );

endmodule

`default_nettype wire

// ==== bench/executeStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStageTb import executePkg::*;;

    localparam int ClkPeriod      = 20;
    localparam int DirectedAluOps = 26 * 25;
    localparam int RandomAluOps   = 300;
    localparam int HiLoPairOps    = 12 * 25;
    localparam int HiLoRandomOps  = 200;
    localparam int BranchOps      = 7 * 10;
    localparam int MixOps         = 600;
    localparam int TotalOps       = DirectedAluOps + RandomAluOps + HiLoPairOps
                                  + HiLoRandomOps + BranchOps + MixOps + 2;

    localparam logic [31:0] Corners [0:4] = '{32'h0000_0000, 32'hFFFF_FFFF,
                                              32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0001};
    localparam logic [5:0] AluCodes [0:25] = '{opAdd, opAddu, opSub, opSubu, opMul, opLui,
        opAnd, opOr, opNor, opXor, opSeh, opSeb, opSll, opSllv, opSrl, opSrlv, opSra,
        opSrav, opRotr, opRotrv, opSlt, opSltu, opAbs, opLa, opMovn, opMovz};
    localparam logic [5:0] HiLoCodes [0:7] = '{opMult, opMultu, opMadd, opMsub,
        opMthi, opMtlo, opMfhi, opMflo};
    localparam logic [5:0] BranchCodes [0:6] = '{opBeq, opBne, opBgez, opBgtz, opBlez,
        opBltz, opJump};

    logic          Clk;
    logic          reset;
    issueBundleT   Issue;
    executeResultT Execute;

    executeResultT expQ [$];                    // Expected outputs in issue order
    string         nameQ [$];
    logic          branchQ [$];                 // Target compared for branches only
    logic [31:0]   shadowHi;                    // Model copy of HI/LO
    logic [31:0]   shadowLo;
    int            mismatchCount;
    int            propertyCount;

    executeStage dut_i (
        .Clk     (Clk),
        .reset   (reset),
        .Issue   (Issue),
        .Execute (Execute)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    // --------------------
    // Output properties
    // --------------------
    resetClears: assert property (@(posedge Clk)
        reset |=> (!Execute.Valid && !Execute.RegWrite && !Execute.BranchTaken))
    else begin
        propertyCount++;
        $display("Control outputs stayed high after a reset cycle");
    end

    zeroTracksResult: assert property (@(posedge Clk) disable iff (reset)
        Execute.Valid |-> (Execute.Zero == (Execute.Result == '0)))
    else begin
        propertyCount++;
        $display("Zero flag disagrees with the result word");
    end

    bubbleQuiet: assert property (@(posedge Clk) disable iff (reset)
        !Execute.Valid |-> (!Execute.RegWrite && !Execute.BranchTaken))
    else begin
        propertyCount++;
        $display("A bubble left the stage with write or branch set");
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic logic isBranch(logic [5:0] code);
        return code inside {opBeq, opBne, opBgez, opBgtz, opBlez, opBltz, opJump};
    endfunction

    function automatic executeResultT modelResult(issueBundleT op);
        executeResultT r;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   res;
        logic [4:0]    v;
        logic          cond;
        logic          moveOk;
        a      = op.A;
        b      = op.B;
        v      = op.A[4:0];                     // Variable shift amount
        res    = 32'h0;
        cond   = 1'b0;
        moveOk = 1'b1;
        case (op.ALUControl)
            opAdd, opAddu: res = a + b;
            opSub, opSubu: res = a - b;
            opMul:   res = a * b;
            opLui:   res = b << 16;
            opAnd:   res = a & b;
            opOr:    res = a | b;
            opNor:   res = ~a & ~b;
            opXor:   res = a ^ b;
            opSeh:   res = {{16{b[15]}}, b[15:0]};
            opSeb:   res = {{24{b[7]}}, b[7:0]};
            opSll:   res = b << op.Shamt;
            opSllv:  res = b << v;
            opSrl:   res = b >> op.Shamt;
            opSrlv:  res = b >> v;
            opSra:   res = (b >> op.Shamt) | (b[31] ? ~(32'hFFFF_FFFF >> op.Shamt) : 32'h0);
            opSrav:  res = (b >> v) | (b[31] ? ~(32'hFFFF_FFFF >> v) : 32'h0);
            opRotr:  res = (b >> op.Shamt) | (b << (6'd32 - {1'b0, op.Shamt}));
            opRotrv: res = (b >> v) | (b << (6'd32 - {1'b0, v}));
            opSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opSltu:  res = (a < b) ? 32'd1 : 32'd0;
            opAbs:   res = a[31] ? (~a + 32'd1) : a;
            opLa:    res = b & 32'h00FF_FFFF;
            opMovn: begin
                moveOk = (b != 32'h0);
                res    = moveOk ? a : 32'h0;
            end
            opMovz: begin
                moveOk = (b == 32'h0);
                res    = moveOk ? a : 32'h0;
            end
            opMfhi:  res = shadowHi;
            opMflo:  res = shadowLo;
            opBeq:   cond = (a == b);
            opBne:   cond = (a != b);
            opBgez:  cond = !a[31];
            opBgtz:  cond = !a[31] && (a != 32'h0);
            opBlez:  cond = a[31] || (a == 32'h0);
            opBltz:  cond = a[31];
            opJump:  cond = 1'b1;
            default: res = 32'h0;               // HI/LO writers and unused codes
        endcase
        r.Valid        = op.Valid;
        r.RegWrite     = op.Valid && op.RegWrite && moveOk;
        r.DestReg      = op.DestReg;
        r.Result       = res;
        r.Zero         = (res == 32'h0);
        r.BranchTaken  = op.Valid && cond;
        r.BranchTarget = (op.ALUControl == opJump) ? a
                       : op.PcPlus4 + {{14{op.BranchOffset[15]}}, op.BranchOffset, 2'b00};
        return r;
    endfunction

    task automatic updateShadow(issueBundleT op);
        logic [63:0] pair;
        logic [63:0] prodS;
        logic [63:0] prodU;
        pair  = {shadowHi, shadowLo};
        prodS = {{32{op.A[31]}}, op.A} * {{32{op.B[31]}}, op.B};   // Low 64 bits exact
        prodU = {32'h0, op.A} * {32'h0, op.B};
        case (op.ALUControl)
            opMult:  pair = prodS;
            opMultu: pair = prodU;
            opMadd:  pair = pair + prodS;
            opMsub:  pair = pair - prodS;
            opMthi:  pair[63:32] = op.A;
            opMtlo:  pair[31:0] = op.A;
            default: pair = pair;
        endcase
        shadowHi = pair[63:32];
        shadowLo = pair[31:0];
    endtask

    // --------------------
    // Drive and compare
    // --------------------
    task automatic reportValue(string name, string field, logic [31:0] expected,
                               logic [31:0] actual);
        mismatchCount++;
        $display("[ERROR] %s %s expected %h actual %h", name, field, expected, actual);
    endtask

    task automatic checkOldest();
        executeResultT exp;
        string         name;
        logic          branch;
        exp    = expQ.pop_front();
        name   = nameQ.pop_front();
        branch = branchQ.pop_front();
        assert (Execute.Valid == exp.Valid)
            else reportValue(name, "Valid", 32'(exp.Valid), 32'(Execute.Valid));
        assert (Execute.RegWrite == exp.RegWrite)
            else reportValue(name, "RegWrite", 32'(exp.RegWrite), 32'(Execute.RegWrite));
        assert (Execute.BranchTaken == exp.BranchTaken)
            else reportValue(name, "BranchTaken", 32'(exp.BranchTaken),
                             32'(Execute.BranchTaken));
        if (exp.Valid) begin
            assert (Execute.DestReg == exp.DestReg)
                else reportValue(name, "DestReg", 32'(exp.DestReg), 32'(Execute.DestReg));
            assert (Execute.Result == exp.Result)
                else reportValue(name, "Result", exp.Result, Execute.Result);
            assert (Execute.Zero == exp.Zero)
                else reportValue(name, "Zero", 32'(exp.Zero), 32'(Execute.Zero));
            if (branch) begin
                assert (Execute.BranchTarget == exp.BranchTarget)
                    else reportValue(name, "BranchTarget", exp.BranchTarget,
                                     Execute.BranchTarget);
            end
        end
    endtask

    task automatic driveCycle(issueBundleT op, string name);
        @(negedge Clk);
        if (expQ.size() == 2) begin
            checkOldest();                      // Issued two cycles ago
        end else begin
            assert (!Execute.Valid && !Execute.RegWrite && !Execute.BranchTaken)
                else reportValue("idle after reset", "control bits", 32'h0,
                    {29'h0, Execute.Valid, Execute.RegWrite, Execute.BranchTaken});
        end
        Issue = op;
        expQ.push_back(modelResult(op));
        nameQ.push_back(name);
        branchQ.push_back(isBranch(op.ALUControl));
        if (op.Valid) begin
            updateShadow(op);                   // Bubbles leave HI/LO alone
        end
    endtask

    task automatic issueOp(logic valid, logic [5:0] code, logic [31:0] a, logic [31:0] b,
                           logic [4:0] shamt, logic [15:0] offset, string name);
        issueBundleT op;
        op.Valid        = valid;
        op.RegWrite     = 1'b1;
        op.ALUControl   = code;
        op.A            = a;
        op.B            = b;
        op.Shamt        = shamt;
        op.DestReg      = 5'($urandom);
        op.PcPlus4      = $urandom & 32'hFFFF_FFFC;
        op.BranchOffset = offset;
        driveCycle(op, $sformatf("%s code %0d", name, code));
    endtask

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        #((TotalOps + 50) * ClkPeriod);
        $display("Run timed out before all operations were checked");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [5:0]  code;
        issueBundleT op;
        void'($urandom(32'h173d));
        mismatchCount    = 0;
        propertyCount    = 0;
        shadowHi         = 32'h0;
        shadowLo         = 32'h0;
        Issue            = '0;
        Issue.Valid      = 1'b1;                // Taken jump held through reset
        Issue.RegWrite   = 1'b1;
        Issue.ALUControl = opJump;
        reset            = 1'b1;
        repeat (10) @(negedge Clk);
        reset = 1'b0;
        Issue = '0;

        // Corner operands, shift amounts 0 and 31 included
        foreach (AluCodes[k]) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issueOp(1'b1, AluCodes[k], Corners[i], Corners[j], Corners[j][4:0],
                            16'h0, "alu corner");
                end
            end
        end
        for (int n = 0; n < RandomAluOps; n++) begin
            b = ($urandom_range(0, 3) == 0) ? 32'h0 : $urandom;   // Hit both move cases
            issueOp(1'b1, AluCodes[$urandom_range(0, 25)], $urandom, b, 5'($urandom),
                    16'h0, "alu random");
        end

        // --------------------
        // HI/LO sequences
        // --------------------
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                a = Corners[i];
                b = Corners[j];
                issueOp(1'b1, opMult, a, b, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMfhi, a, b, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMflo, a, b, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMultu, a, b, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMadd, b, a, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMfhi, a, b, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMsub, a, a, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMflo, a, b, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMthi, a, b, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMtlo, b, a, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMfhi, a, b, 5'd0, 16'h0, "hilo pair");
                issueOp(1'b1, opMflo, a, b, 5'd0, 16'h0, "hilo pair");
            end
        end
        for (int n = 0; n < HiLoRandomOps; n++) begin
            a = ($urandom_range(0, 3) == 0) ? Corners[$urandom_range(0, 4)] : $urandom;
            issueOp(1'b1, HiLoCodes[$urandom_range(0, 7)], a, $urandom, 5'd0, 16'h0,
                    "hilo chain");
        end

        // Equal and random B, offsets of either sign
        foreach (BranchCodes[k]) begin
            for (int i = 0; i < 5; i++) begin
                issueOp(1'b1, BranchCodes[k], Corners[i], Corners[i], 5'd0,
                        16'($urandom), "branch equal");
                issueOp(1'b1, BranchCodes[k], Corners[i], $urandom, 5'd0,
                        16'($urandom), "branch random");
            end
        end

        // --------------------
        // Random mix, Valid toggling
        // --------------------
        for (int n = 0; n < MixOps; n++) begin
            code            = 6'($urandom_range(0, 47));      // Unused codes too
            op.Valid        = 1'($urandom_range(0, 1));
            op.RegWrite     = 1'($urandom_range(0, 1));
            op.ALUControl   = code;
            op.A            = $urandom;
            op.B            = ($urandom_range(0, 7) == 0) ? 32'h0 : $urandom;
            op.Shamt        = 5'($urandom);
            op.DestReg      = 5'($urandom);
            op.PcPlus4      = $urandom & 32'hFFFF_FFFC;
            op.BranchOffset = 16'($urandom);
            driveCycle(op, $sformatf("mix code %0d", code));
        end
        driveCycle('0, "flush");
        driveCycle('0, "flush");

        $display("Value errors: %0d, assertion errors: %0d", mismatchCount, propertyCount);
        if (mismatchCount == 0 && propertyCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== executeStage.f ====
hdl/executePkg.sv
hdl/issueRegister.sv
hdl/aluCore.sv
hdl/hiLoUnit.sv
hdl/branchResolve.sv
hdl/resultRegister.sv
hdl/executeStage.sv
bench/executeStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module executeStageTb \
    -f executeStage.f \
    -o executeStageSim

output="$(./obj_dir/executeStageSim)"
echo "$output"

if grep -qx "TESTS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
